// ==== source/gng_pkg.sv ====
`default_nettype none

package gng_pkg;

	// Game side colour, 4 bits per channel
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb4_t;

	// VGA side colour, 6 bits per channel
	typedef struct packed {
		logic [5:0] red;
		logic [5:0] green;
		logic [5:0] blue;
	} rgb6_t;

	typedef struct packed {
		logic [8:0] hcount;
		logic [8:0] vcount;
		logic       pix_cen;   // One clock per game pixel
		logic       lhbl;      // High in horizontal active
		logic       lvbl;      // High in vertical active
	} game_timing_t;

	typedef struct packed {
		logic hsync;   // Active low
		logic vsync;   // Active low
		logic de;
	} vga_sync_t;

	typedef struct packed {
		logic game_mode;
		logic upright;
		logic noflip;
		logic attract_snd;
	} dip_cfg_t;

	typedef enum logic [1:0] {ST_HOLD, ST_LOAD, ST_RUN} rst_state_t;

	// Default raster, in game pixels and game lines
	localparam int DEF_H_TOTAL     = 32;
	localparam int DEF_H_ACTIVE    = 24;
	localparam int DEF_V_TOTAL     = 12;
	localparam int DEF_V_ACTIVE    = 8;
	localparam int DEF_HOLD_CYCLES = 4;

endpackage

`default_nettype wire

// ==== source/gng_reset_seq.sv ====
`default_nettype none

module gng_reset_seq #(
	parameter int HOLD_CYCLES = 4
) (
	input  wire logic              clk_gng,
	input  wire logic              rst_n,
	input  wire logic              downloading,
	input  wire logic              soft_rst,
	input  wire gng_pkg::dip_cfg_t dip_in,
	output logic                   game_rst,
	output gng_pkg::dip_cfg_t      dip
);

	localparam int CW = $clog2(HOLD_CYCLES + 1);

	gng_pkg::rst_state_t state;
	gng_pkg::rst_state_t state_nxt;
	logic [CW-1:0]       hold_cnt;
	logic                hold_done;

	assign hold_done = hold_cnt == CW'(HOLD_CYCLES - 1); // Last clock of the hold window

	always_comb begin
		state_nxt = state;
		case (state)
			gng_pkg::ST_HOLD: begin
				if (hold_done) begin
					// Skip the load state when no ROM is coming in
					state_nxt = downloading ? gng_pkg::ST_LOAD : gng_pkg::ST_RUN;
				end
			end
			gng_pkg::ST_LOAD: begin
				if (!downloading) begin
					state_nxt = gng_pkg::ST_RUN;
				end
			end
			gng_pkg::ST_RUN: begin
				if (soft_rst) begin
					state_nxt = gng_pkg::ST_HOLD;
				end
			end
			default: state_nxt = gng_pkg::ST_HOLD;
		endcase
	end

	always_ff @(posedge clk_gng) begin
		if (!rst_n) begin
			state    <= gng_pkg::ST_HOLD;
			hold_cnt <= '0;
			dip      <= '0;
		end else begin
			state <= state_nxt;
			// Counter only runs while holding, cleared everywhere else
			if (state == gng_pkg::ST_HOLD) begin
				hold_cnt <= hold_cnt + 1'b1;
			end else begin
				hold_cnt <= '0;
			end
			if (state != gng_pkg::ST_RUN && state_nxt == gng_pkg::ST_RUN) begin
				dip <= dip_in; // Switch settings frozen until next reset
			end
		end
	end

	assign game_rst = state != gng_pkg::ST_RUN;

endmodule

`default_nettype wire

// ==== source/gng_video_timer.sv ====
`default_nettype none

module gng_video_timer #(
	parameter int H_TOTAL  = 32,
	parameter int H_ACTIVE = 24,
	parameter int V_TOTAL  = 12,
	parameter int V_ACTIVE = 8
) (
	input  wire logic              clk_gng,
	input  wire logic              rst_n,
	output gng_pkg::game_timing_t  timing
);

	logic       cen;
	logic [8:0] h_cnt;
	logic [8:0] v_cnt;
	logic       h_last;
	logic       v_last;

	assign h_last = h_cnt == 9'(H_TOTAL - 1);
	assign v_last = v_cnt == 9'(V_TOTAL - 1);

	// Pixel enable at half the clock rate
	always_ff @(posedge clk_gng) begin
		if (!rst_n) begin
			cen <= 1'b0;
		end else begin
			cen <= ~cen;
		end
	end

	// Counters start on the last blank pixel of the last line, so the
	// first pixel enable opens a fresh frame at 0,0
	always_ff @(posedge clk_gng) begin
		if (!rst_n) begin
			h_cnt <= 9'(H_TOTAL - 1);
			v_cnt <= 9'(V_TOTAL - 1);
		end else if (cen) begin
			if (h_last) begin
				h_cnt <= '0;
				if (v_last) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	assign timing = '{
		hcount:  h_cnt,
		vcount:  v_cnt,
		pix_cen: cen,
		lhbl:    h_cnt < 9'(H_ACTIVE),
		lvbl:    v_cnt < 9'(V_ACTIVE)
	};

endmodule

`default_nettype wire

// ==== source/gng_line_doubler.sv ====
`default_nettype none

module gng_line_doubler #(
	parameter int H_TOTAL  = 32,
	parameter int H_ACTIVE = 24,
	parameter int V_TOTAL  = 12,
	parameter int V_ACTIVE = 8
) (
	input  wire logic                  clk_gng,
	input  wire logic                  rst_n,
	input  wire gng_pkg::game_timing_t timing,
	input  wire gng_pkg::rgb4_t        game_pixel,
	output gng_pkg::rgb4_t             pixel,
	output gng_pkg::vga_sync_t         sync,
	output logic [8:0]                 out_x,
	output logic [8:0]                 out_y
);

	localparam int XW      = $clog2(H_TOTAL);
	localparam int VS_LINE = (V_ACTIVE + 1) % V_TOTAL; // Game line under the vsync pulse

	gng_pkg::rgb4_t line_buf [0:(2 ** (XW + 1)) - 1]; // Two banks of one game line each

	logic               line_end;
	logic               wr_bank;
	logic               phase;        // Which copy of the line is playing
	logic               lvbl_q;
	logic [8:0]         rd_x;
	logic [8:0]         shown_line;
	gng_pkg::rgb4_t     rd_q;
	gng_pkg::vga_sync_t sync_s0;
	gng_pkg::vga_sync_t sync_s1;
	logic [8:0]         x_s1;
	logic [8:0]         y_s1;

	// Last pixel enable of a game line, always in horizontal blank
	assign line_end = timing.pix_cen && timing.hcount == 9'(H_TOTAL - 1);

	always_ff @(posedge clk_gng) begin
		if (timing.pix_cen && timing.lhbl && timing.lvbl) begin
			line_buf[{wr_bank, timing.hcount[XW-1:0]}] <= game_pixel;
		end
	end

	always_ff @(posedge clk_gng) begin
		rd_q <= line_buf[{~wr_bank, rd_x[XW-1:0]}]; // Previous game line
	end

	// Output counter at clock rate, realigned at every game line boundary
	always_ff @(posedge clk_gng) begin
		if (!rst_n) begin
			wr_bank    <= 1'b0;
			rd_x       <= '0;
			phase      <= 1'b0;
			lvbl_q     <= 1'b0;
			shown_line <= '0;
		end else if (line_end) begin
			wr_bank    <= ~wr_bank;
			rd_x       <= '0;
			phase      <= 1'b0;
			lvbl_q     <= timing.lvbl;   // Line just written is the one shown next
			shown_line <= timing.vcount;
		end else if (rd_x == 9'(H_TOTAL - 1)) begin
			rd_x  <= '0;
			phase <= ~phase;
		end else begin
			rd_x <= rd_x + 1'b1;
		end
	end

	assign sync_s0 = '{
		hsync: !(rd_x >= 9'(H_ACTIVE + 2) && rd_x < 9'(H_ACTIVE + 6)),
		vsync: shown_line != 9'(VS_LINE),
		de:    lvbl_q && rd_x < 9'(H_ACTIVE)
	};

	// Syncs follow the two clock RAM and blanking path
	always_ff @(posedge clk_gng) begin
		if (!rst_n) begin
			sync_s1 <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};
			sync    <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};
		end else begin
			sync_s1 <= sync_s0;
			sync    <= sync_s1;
		end
	end

	always_ff @(posedge clk_gng) begin
		x_s1  <= rd_x;
		y_s1  <= {timing.vcount[7:0], phase}; // VGA line 2k+m during game line k
		out_x <= x_s1;
		out_y <= y_s1;
		pixel <= sync_s1.de ? rd_q : '0;      // Black outside display enable
	end

endmodule

`default_nettype wire

// ==== source/gng_osd_overlay.sv ====
`default_nettype none

module gng_osd_overlay #(
	parameter int BOX_X0 = 6,
	parameter int BOX_X1 = 15,
	parameter int BOX_Y0 = 6,
	parameter int BOX_Y1 = 11
) (
	input  wire logic               clk_gng,
	input  wire logic               rst_n,
	input  wire logic               osd_show,
	input  wire gng_pkg::rgb4_t     pixel,
	input  wire gng_pkg::vga_sync_t sync,
	input  wire logic [8:0]         in_x,
	input  wire logic [8:0]         in_y,
	output gng_pkg::rgb6_t          vga_pixel,
	output gng_pkg::vga_sync_t      vga_sync
);

	gng_pkg::rgb6_t wide;
	gng_pkg::rgb6_t pix_nxt;
	logic           in_box;

	// Top bits repeated below, off by one LSB on a few codes only
	function automatic logic [5:0] expand(input logic [3:0] c);
		return {c, c[3:2]};
	endfunction

	assign wide = '{
		red:   expand(pixel.red),
		green: expand(pixel.green),
		blue:  expand(pixel.blue)
	};

	// Inclusive window, only over displayed pixels
	assign in_box = sync.de &&
		in_x >= 9'(BOX_X0) && in_x <= 9'(BOX_X1) &&
		in_y >= 9'(BOX_Y0) && in_y <= 9'(BOX_Y1);

	always_comb begin
		pix_nxt = wide;
		if (osd_show) begin
			if (in_box) begin
				pix_nxt = '1; // White fill
			end else begin
				pix_nxt.red   = wide.red >> 1;
				pix_nxt.green = wide.green >> 1;
				pix_nxt.blue  = wide.blue >> 1;
			end
		end
	end

	always_ff @(posedge clk_gng) begin
		if (!rst_n) begin
			vga_pixel <= '0;
			vga_sync  <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};
		end else begin
			vga_pixel <= pix_nxt;
			vga_sync  <= sync;
		end
	end

endmodule

`default_nettype wire

// ==== source/gng_video_top.sv ====
`default_nettype none

module gng_video_top #(
	parameter int H_TOTAL     = gng_pkg::DEF_H_TOTAL,
	parameter int H_ACTIVE    = gng_pkg::DEF_H_ACTIVE,
	parameter int V_TOTAL     = gng_pkg::DEF_V_TOTAL,
	parameter int V_ACTIVE    = gng_pkg::DEF_V_ACTIVE,
	parameter int HOLD_CYCLES = gng_pkg::DEF_HOLD_CYCLES,
	parameter int BOX_X0      = 6,
	parameter int BOX_X1      = 15,
	parameter int BOX_Y0      = 6,
	parameter int BOX_Y1      = 11
) (
	input  wire logic              clk_gng,
	input  wire logic              rst_n,
	input  wire logic              downloading,
	input  wire logic              soft_rst,
	input  wire gng_pkg::dip_cfg_t dip_in,
	input  wire gng_pkg::rgb4_t    game_pixel,
	input  wire logic              osd_show,
	output logic                   game_rst,
	output gng_pkg::dip_cfg_t      dip,
	output gng_pkg::game_timing_t  timing,
	output gng_pkg::rgb6_t         vga_pixel,
	output gng_pkg::vga_sync_t     vga_sync
);

	gng_pkg::rgb4_t     dbl_pixel;
	gng_pkg::vga_sync_t dbl_sync;
	logic [8:0]         dbl_x;
	logic [8:0]         dbl_y;

	gng_reset_seq #(.HOLD_CYCLES(HOLD_CYCLES)) i_reset_seq (
		.clk_gng     (clk_gng),
		.rst_n       (rst_n),
		.downloading (downloading),
		.soft_rst    (soft_rst),
		.dip_in      (dip_in),
		.game_rst    (game_rst),
		.dip         (dip)
	);

	gng_video_timer #(
		.H_TOTAL  (H_TOTAL),
		.H_ACTIVE (H_ACTIVE),
		.V_TOTAL  (V_TOTAL),
		.V_ACTIVE (V_ACTIVE)
	) i_video_timer (
		.clk_gng (clk_gng),
		.rst_n   (rst_n),
		.timing  (timing)  // Out to the game and into the doubler
	);

	gng_line_doubler #(
		.H_TOTAL  (H_TOTAL),
		.H_ACTIVE (H_ACTIVE),
		.V_TOTAL  (V_TOTAL),
		.V_ACTIVE (V_ACTIVE)
	) i_line_doubler (
		.clk_gng    (clk_gng),
		.rst_n      (rst_n),
		.timing     (timing),
		.game_pixel (game_pixel),
		.pixel      (dbl_pixel),
		.sync       (dbl_sync),
		.out_x      (dbl_x),
		.out_y      (dbl_y)
	);

	gng_osd_overlay #(
		.BOX_X0 (BOX_X0),
		.BOX_X1 (BOX_X1),
		.BOX_Y0 (BOX_Y0),
		.BOX_Y1 (BOX_Y1)
	) i_osd_overlay (
		.clk_gng   (clk_gng),
		.rst_n     (rst_n),
		.osd_show  (osd_show),
		.pixel     (dbl_pixel),
		.sync      (dbl_sync),
		.in_x      (dbl_x),
		.in_y      (dbl_y),
		.vga_pixel (vga_pixel),
		.vga_sync  (vga_sync)
	);

endmodule

`default_nettype wire

// ==== verification/gng_video_tests.svh ====
task automatic report(input string what, input logic [31:0] exp, input logic [31:0] act);
	$display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
	errors++;
endtask

// Compares the VGA outputs with the reference raster
task automatic check_vga();
	int                 x;
	int                 y;
	logic               box;
	gng_pkg::vga_sync_t exp_sync;
	gng_pkg::rgb4_t     src;
	gng_pkg::rgb6_t     exp_pix;
	x = pos % H_TOTAL;
	y = 2 * ((shown + 1) % V_TOTAL) + pos / H_TOTAL; // VGA line 2k+m shows game line k-1
	exp_sync.de    = shown < V_ACTIVE && x < H_ACTIVE;
	exp_sync.hsync = !(x >= H_ACTIVE + 2 && x < H_ACTIVE + 6);
	exp_sync.vsync = shown != (V_ACTIVE + 1) % V_TOTAL;
	src = exp_sync.de ? model_pixel(x, shown) : '0;
	exp_pix = {widen(src.red), widen(src.green), widen(src.blue)};
	box = exp_sync.de && x >= BOX_X0 && x <= BOX_X1 && y >= BOX_Y0 && y <= BOX_Y1;
	if (osd_q && box) begin
		exp_pix = '1;
	end else if (osd_q) begin
		exp_pix = {exp_pix.red >> 1, exp_pix.green >> 1, exp_pix.blue >> 1};
	end
	if (vga_sync !== exp_sync) report("vga_sync", exp_sync, vga_sync);
	if (vga_pixel !== exp_pix) report("vga_pixel", exp_pix, vga_pixel);
	if (vga_sync.de) de_cycles++;
	if (!vga_sync.vsync) vs_cycles++;
	if (osd_q && vga_pixel == '1) box_cycles++;
endtask

task automatic apply_reset(input logic dl, input gng_pkg::dip_cfg_t dip_val);
	@(posedge clk_gng);
	rst_n       <= 1'b0;
	downloading <= dl;
	dip_in      <= dip_val;
	soft_rst    <= 1'b0;
	@(posedge clk_gng);
	@(negedge clk_gng);
	if (game_rst !== 1'b1) report("game_rst in reset", 1, game_rst);
	if (timing[2:0] !== 3'b000) report("pix_cen/lhbl/lvbl in reset", 0, timing[2:0]);
	if (vga_sync !== 3'b110) report("vga_sync in reset", 3'b110, vga_sync);
	if (vga_pixel !== '0) report("vga_pixel in reset", 0, vga_pixel);
	@(posedge clk_gng);
	rst_n <= 1'b1;
endtask

// Counts clocks until the game leaves reset
task automatic wait_game_run(output int n);
	n = 0;
	@(negedge clk_gng);
	while (game_rst && n < 64) begin
		@(negedge clk_gng);
		n++;
	end
endtask

task automatic test_reset_release();
	int n;
	test_name = "reset_release";
	apply_reset(1'b0, '0);
	wait_game_run(n);
	if (n != HOLD_CYCLES) report("hold clocks", HOLD_CYCLES, n);
	apply_reset(1'b1, '0);
	repeat (HOLD_CYCLES + 6) begin
		@(negedge clk_gng);
		if (!game_rst) report("game_rst during download", 1, game_rst);
	end
	@(posedge clk_gng);
	downloading <= 1'b0;
	wait_game_run(n);
	if (n != 1) report("clocks after download", 1, n);
endtask

task automatic test_dip_latch();
	int                n;
	gng_pkg::dip_cfg_t a;
	gng_pkg::dip_cfg_t b;
	test_name = "dip_latch";
	a = 4'(1 + $urandom % 15);     // Nonzero so it differs from the reset value
	b = a ^ 4'(1 + $urandom % 15); // Always differs from a
	apply_reset(1'b0, a);
	wait_game_run(n);
	if (dip !== a) report("dip after reset", a, dip);
	@(posedge clk_gng);
	dip_in <= b;
	repeat (3) @(negedge clk_gng);
	if (dip !== a) report("dip before soft reset", a, dip);
	@(posedge clk_gng);
	soft_rst <= 1'b1;
	@(posedge clk_gng);
	soft_rst <= 1'b0;
	wait_game_run(n);
	if (n != HOLD_CYCLES) report("hold clocks after soft reset", HOLD_CYCLES, n);
	if (dip !== b) report("dip after soft reset", b, dip);
endtask

task automatic test_game_timing();
	int   exp_h;
	int   exp_v;
	int   lhbl_cnt;
	int   lines;
	int   n;
	logic prev_cen;
	test_name = "game_timing";
	n = 0;
	do begin
		@(negedge clk_gng);
		n++;
	end while (!(timing.pix_cen && timing.hcount == 0 && timing.vcount == 0) && n < 2 * FRAME);
	if (n >= 2 * FRAME) begin
		$display("FAIL %s: no frame start seen", test_name);
		errors++;
	end
	exp_h    = 0;
	exp_v    = 0;
	lhbl_cnt = 0;
	lines    = 0;
	prev_cen = 1'b0;
	for (int i = 0; i < FRAME; i++) begin
		if (timing.pix_cen == prev_cen) report("pix_cen toggle", !prev_cen, timing.pix_cen);
		prev_cen = timing.pix_cen;
		if (timing.pix_cen) begin
			if (timing.hcount != exp_h) report("hcount", exp_h, timing.hcount);
			if (timing.vcount != exp_v) report("vcount", exp_v, timing.vcount);
			if (timing.lhbl) lhbl_cnt++;
			if (exp_h == 0 && timing.lvbl) lines++;
			if (exp_h == H_TOTAL - 1) begin
				if (lhbl_cnt != H_ACTIVE) report("lhbl pixels", H_ACTIVE, lhbl_cnt);
				lhbl_cnt = 0;
				exp_v    = (exp_v + 1) % V_TOTAL;
			end
			exp_h = (exp_h + 1) % H_TOTAL;
		end
		@(negedge clk_gng);
	end
	if (lines != V_ACTIVE) report("lvbl lines", V_ACTIVE, lines);
endtask

task automatic test_line_doubling();
	test_name = "line_doubling";
	@(posedge clk_gng);
	osd_show <= 1'b0;
	wait (active);
	@(posedge clk_gng);
	de_cycles = 0;
	vs_cycles = 0;
	repeat (FRAME) @(posedge clk_gng);
	if (de_cycles != 2 * V_ACTIVE * H_ACTIVE) report("de clocks", 2 * V_ACTIVE * H_ACTIVE, de_cycles);
	if (vs_cycles != 2 * H_TOTAL) report("vsync clocks", 2 * H_TOTAL, vs_cycles);
endtask

task automatic test_overlay();
	int exp_box;
	int y;
	test_name = "overlay";
	exp_box = 0;
	for (int s = 0; s < V_ACTIVE; s++) begin
		for (int m = 0; m < 2; m++) begin
			y = 2 * ((s + 1) % V_TOTAL) + m;
			for (int x = 0; x < H_ACTIVE; x++) begin
				if (x >= BOX_X0 && x <= BOX_X1 && y >= BOX_Y0 && y <= BOX_Y1) exp_box++;
			end
		end
	end
	@(posedge clk_gng);
	osd_show <= 1'b1;
	@(posedge clk_gng);
	box_cycles = 0;
	repeat (FRAME) @(posedge clk_gng);
	if (box_cycles != exp_box) report("box clocks", exp_box, box_cycles);
	osd_show <= 1'b0;
	repeat (4) @(posedge clk_gng);
endtask

// ==== verification/gng_video_tb.sv ====
`default_nettype none

module gng_video_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int H_TOTAL     = gng_pkg::DEF_H_TOTAL;
	localparam int H_ACTIVE    = gng_pkg::DEF_H_ACTIVE;
	localparam int V_TOTAL     = gng_pkg::DEF_V_TOTAL;
	localparam int V_ACTIVE    = gng_pkg::DEF_V_ACTIVE;
	localparam int HOLD_CYCLES = gng_pkg::DEF_HOLD_CYCLES;
	localparam int BOX_X0      = 6;
	localparam int BOX_X1      = 15;
	localparam int BOX_Y0      = 6;
	localparam int BOX_Y1      = 11;
	localparam int FRAME       = V_TOTAL * 2 * H_TOTAL; // Clocks per game frame
	localparam int LIMIT       = 2 * (4 * FRAME + 200); // One alignment frame and three measured

	logic                  clk_gng = 1'b0;
	logic                  rst_n;
	logic                  downloading;
	logic                  soft_rst;
	gng_pkg::dip_cfg_t     dip_in;
	gng_pkg::rgb4_t        game_pixel;
	logic                  osd_show;
	logic                  game_rst;
	gng_pkg::dip_cfg_t     dip;
	gng_pkg::game_timing_t timing;
	gng_pkg::rgb6_t        vga_pixel;
	gng_pkg::vga_sync_t    vga_sync;

	int    errors = 0;
	int    cycle = 0;
	string test_name = "idle";
	int    start_cyc[$];   // Clock at which each game line starts on VGA
	int    start_line[$];
	logic  active = 1'b0;  // Reference raster locked to the DUT
	int    pos;            // Clock within the current game line period
	int    shown;          // Game line on screen
	logic  osd_q = 1'b0;
	int    de_cycles;
	int    vs_cycles;
	int    box_cycles;

	always #2 clk_gng = ~clk_gng;

	gng_video_top #(
		.H_TOTAL     (H_TOTAL),
		.H_ACTIVE    (H_ACTIVE),
		.V_TOTAL     (V_TOTAL),
		.V_ACTIVE    (V_ACTIVE),
		.HOLD_CYCLES (HOLD_CYCLES),
		.BOX_X0      (BOX_X0),
		.BOX_X1      (BOX_X1),
		.BOX_Y0      (BOX_Y0),
		.BOX_Y1      (BOX_Y1)
	) i_dut (
		.clk_gng     (clk_gng),
		.rst_n       (rst_n),
		.downloading (downloading),
		.soft_rst    (soft_rst),
		.dip_in      (dip_in),
		.game_pixel  (game_pixel),
		.osd_show    (osd_show),
		.game_rst    (game_rst),
		.dip         (dip),
		.timing      (timing),
		.vga_pixel   (vga_pixel),
		.vga_sync    (vga_sync)
	);

	// Game stand-in that answers the counts shown on timing
	function automatic gng_pkg::rgb4_t model_pixel(input int h, input int v);
		gng_pkg::rgb4_t p;
		p.red   = 4'(h);
		p.green = 4'(v);
		p.blue  = 4'(h + v);
		return p;
	endfunction

	function automatic logic [5:0] widen(input logic [3:0] c);
		return (6'(c) << 2) | 6'(c >> 2);
	endfunction

	always @(posedge clk_gng) begin
		game_pixel <= model_pixel(timing.hcount, timing.vcount);
	end

	always @(posedge clk_gng) begin
		cycle = cycle + 1;
		if (cycle >= LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	`include "gng_video_tests.svh"

	// Reference raster where pixel 0 of a game line shows 2*H_TOTAL+2 clocks after its pix_cen
	always @(negedge clk_gng) begin
		if (!rst_n) begin
			active = 1'b0;
			osd_q  = 1'b0;
			start_cyc.delete();
			start_line.delete();
		end else begin
			if (timing.pix_cen && timing.hcount == 0) begin
				start_cyc.push_back(cycle + 2 * H_TOTAL + 2);
				start_line.push_back(timing.vcount);
			end
			if (start_cyc.size() > 0 && start_cyc[0] == cycle) begin
				void'(start_cyc.pop_front());
				shown  = start_line.pop_front();
				pos    = 0;
				active = 1'b1;
			end else begin
				pos++;
			end
			if (active) begin
				check_vga();
			end
			osd_q = osd_show;
		end
	end

	initial begin
		rst_n       = 1'b0;
		downloading = 1'b0;
		soft_rst    = 1'b0;
		dip_in      = '0;
		game_pixel  = '0;
		osd_show    = 1'b0;
		void'($urandom(32'hb931_83ad));
		test_reset_release();
		test_dip_latch();
		test_game_timing();
		test_line_doubling();
		test_overlay();
		$display("Run complete: %0d errors in %0d cycles", errors, cycle);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== gng_video.f ====
source/gng_pkg.sv
source/gng_reset_seq.sv
source/gng_video_timer.sv
source/gng_line_doubler.sv
source/gng_osd_overlay.sv
source/gng_video_top.sv
+incdir+verification
verification/gng_video_tb.sv
